/* common/sdram_pkg.sv */
`default_nettype none

package sdram_pkg;

	// ----------------------------------------------------------
	// Device geometry
	// ----------------------------------------------------------
	localparam int ba_width   = 2;  // Four banks
	localparam int row_width  = 13; // 8192 rows, also the address pin width
	localparam int col_width  = 9;  // 512 columns per row
	localparam int dq_width   = 16; // One x16 device
	localparam int len_width  = 10; // Bursts of 1 to 1023 words
	localparam int dly_width  = 10; // Shared sequencer delay counter
	localparam int addr_width = ba_width + row_width + col_width;

	typedef logic [ba_width-1:0]   bank_t;
	typedef logic [row_width-1:0]  row_t;
	typedef logic [col_width-1:0]  col_t;
	typedef logic [dq_width-1:0]   dq_t;
	typedef logic [addr_width-1:0] app_addr_t; // {bank, row, col}
	typedef logic [len_width-1:0]  burst_len_t;

	// ----------------------------------------------------------
	// Operations and sequencer states
	// ----------------------------------------------------------
	typedef enum logic [2:0] {
		op_nop,
		op_precharge_all, // A10 high, all banks
		op_auto_refresh,
		op_load_mode,
		op_activate,      // Opens bank/row
		op_read,          // Full-page read from col
		op_write,         // Full-page write from col
		op_burst_stop
	} sdram_op_t;

	typedef enum logic [4:0] {
		st_pwr_wait,
		st_init_pre, st_init_trp,
		st_init_ar1, st_init_trf1,
		st_init_ar2, st_init_trf2,
		st_init_mrs, st_init_tmrd,
		st_idle,
		st_act_wait,
		st_read, st_cas_wait, st_rd_data,
		st_write, st_wr_data, st_wr_rec,
		st_pre, st_pre_wait,
		st_ref, st_ref_wait
	} seq_state_t;

	// One operation from sequencer to encoder
	typedef struct packed {
		sdram_op_t op;
		bank_t     bank;       // Activate, read, write only
		row_t      row;
		col_t      col;
		logic      wr_drive;   // Bus carries a write word
		logic      rd_capture; // Read word due two cycles after the encoder
	} seq_ctrl_t;

endpackage

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the SDRAM controller testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f vlog.f \
	--top-module tb_sdram_ctrl -Mdir obj_dir -o tb_sdram_ctrl
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_sdram_ctrl > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Regression failed" sim.log; then
	exit 1
fi
exit 0

/* sdram_ctrl/sdram_cmd_encoder.sv */
`timescale 1ns/1ps
`default_nettype none

module sdram_cmd_encoder #(
	parameter int cas_latency = 3
) (
	input  wire                  clk,
	input  wire                  rst,
	input  wire sdram_pkg::seq_ctrl_t seq_ctrl,
	output logic                 ras_n,
	output logic                 cas_n,
	output logic                 we_n,
	output sdram_pkg::bank_t     ba,
	output sdram_pkg::row_t      addr,
	output logic                 wr_drive,
	output logic                 rd_capture
);

	import sdram_pkg::*;

	// Full page, sequential, burst write, CAS latency in A6..A4
	localparam row_t mode_word = {3'b000, 1'b0, 2'b00, 3'(cas_latency), 1'b0, 3'b111};

	logic [2:0] cmd_nxt;  // {ras_n, cas_n, we_n}
	bank_t      ba_nxt;
	row_t       addr_nxt;
	row_t       col_addr; // Column with A10 low, no auto precharge
	logic       row_open; // Tracks activate versus precharge

	assign col_addr = row_t'(seq_ctrl.col);

	always_comb
	begin
		cmd_nxt  = 3'b111; // NOP, bank and address all ones
		ba_nxt   = '1;
		addr_nxt = '1;
		case (seq_ctrl.op)
			op_precharge_all: cmd_nxt = 3'b010;
			op_auto_refresh:  cmd_nxt = 3'b001;
			op_burst_stop:    cmd_nxt = 3'b110;
			op_load_mode:
			begin
				cmd_nxt  = 3'b000;
				ba_nxt   = '0;
				addr_nxt = mode_word;
			end
			op_activate:
			begin
				cmd_nxt  = 3'b011;
				ba_nxt   = seq_ctrl.bank;
				addr_nxt = seq_ctrl.row;
			end
			op_read, op_write:
			begin
				cmd_nxt  = (seq_ctrl.op == op_read) ? 3'b101 : 3'b100;
				ba_nxt   = seq_ctrl.bank;
				addr_nxt = col_addr;
			end
			default: cmd_nxt = 3'b111;
		endcase
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			{ras_n, cas_n, we_n} <= 3'b111;
			ba         <= '1;
			addr       <= '1;
			wr_drive   <= 1'b0;
			rd_capture <= 1'b0;
			row_open   <= 1'b0;
		end
		else
		begin
			{ras_n, cas_n, we_n} <= cmd_nxt;
			ba         <= ba_nxt;
			addr       <= addr_nxt;
			wr_drive   <= seq_ctrl.wr_drive;   // Aligned with the pins
			rd_capture <= seq_ctrl.rd_capture;
			if (seq_ctrl.op == op_activate)
				row_open <= 1'b1;
			else if (seq_ctrl.op == op_precharge_all)
				row_open <= 1'b0;
		end
	end

	a_one_row_open: assert property (@(posedge clk) disable iff (rst)
		(seq_ctrl.op == op_activate) |-> !row_open);

endmodule

`default_nettype wire

/* sdram_ctrl/sdram_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module sdram_ctrl #(
	parameter int power_up_cycles  = 20000,
	parameter int refresh_interval = 750,
	parameter int t_rp             = 4,
	parameter int t_rc             = 6,
	parameter int t_mrd            = 6,
	parameter int t_rcd            = 2,
	parameter int t_wr             = 3,
	parameter int cas_latency      = 3
) (
	input  wire                        clk,
	input  wire                        rst,
	input  wire                        wr_burst_req,
	input  wire sdram_pkg::burst_len_t wr_burst_len,
	input  wire sdram_pkg::app_addr_t  wr_burst_addr,
	input  wire sdram_pkg::dq_t        wr_burst_data,
	output logic                       wr_burst_data_req,
	output logic                       wr_burst_finish,
	input  wire                        rd_burst_req,
	input  wire sdram_pkg::burst_len_t rd_burst_len,
	input  wire sdram_pkg::app_addr_t  rd_burst_addr,
	output sdram_pkg::dq_t             rd_burst_data,
	output logic                       rd_burst_data_valid,
	output logic                       rd_burst_finish,
	output logic                       sdram_cke,
	output logic                       sdram_cs_n,
	output logic                       sdram_ras_n,
	output logic                       sdram_cas_n,
	output logic                       sdram_we_n,
	output sdram_pkg::bank_t           sdram_ba,
	output sdram_pkg::row_t            sdram_addr,
	output logic [sdram_pkg::dq_width/8-1:0] sdram_dqm,
	inout  wire sdram_pkg::dq_t        sdram_dq
);

	import sdram_pkg::*;

	logic      init_go, ref_req, ref_ack;
	seq_ctrl_t seq_ctrl;
	logic      wr_drive, rd_capture; // Encoder to data path, aligned with the pins

	assign sdram_cke  = 1'b1;
	assign sdram_cs_n = 1'b0;
	assign sdram_dqm  = '0; // No byte masking

	sdram_refresh_timer #(.power_up_cycles(power_up_cycles), .refresh_interval(refresh_interval))
		u_timer (.clk, .rst, .ref_ack, .init_go, .ref_req);

	sdram_sequencer #(.t_rp(t_rp), .t_rc(t_rc), .t_mrd(t_mrd), .t_rcd(t_rcd), .t_wr(t_wr),
		.cas_latency(cas_latency)) u_seq (.clk, .rst, .init_go, .ref_req, .ref_ack,
		.wr_burst_req, .rd_burst_req, .wr_burst_len, .rd_burst_len, .wr_burst_addr,
		.rd_burst_addr, .wr_burst_data_req, .rd_burst_data_valid, .seq_ctrl);

	sdram_cmd_encoder #(.cas_latency(cas_latency)) u_enc (.clk, .rst, .seq_ctrl,
		.ras_n(sdram_ras_n), .cas_n(sdram_cas_n), .we_n(sdram_we_n), .ba(sdram_ba),
		.addr(sdram_addr), .wr_drive, .rd_capture);

	sdram_data_path u_dp (.clk, .rst, .wr_drive, .rd_capture, .wr_burst_data, .rd_burst_data,
		.wr_burst_data_req, .rd_burst_data_valid, .wr_burst_finish, .rd_burst_finish, .sdram_dq);

endmodule

`default_nettype wire

/* sdram_ctrl/sdram_data_path.sv */
`timescale 1ns/1ps
`default_nettype none

module sdram_data_path (
	input  wire               clk,
	input  wire               rst,
	input  wire               wr_drive,
	input  wire               rd_capture,
	input  wire sdram_pkg::dq_t wr_burst_data,
	output sdram_pkg::dq_t    rd_burst_data,
	input  wire               wr_burst_data_req,
	input  wire               rd_burst_data_valid,
	output logic              wr_burst_finish,
	output logic              rd_burst_finish,
	inout  wire sdram_pkg::dq_t sdram_dq
);

	import sdram_pkg::*;

	dq_t  wr_data_q; // Word on the bus during a write
	logic dq_oe;
	logic rd_pend;   // Read word is on dq this cycle
	logic wr_req_d;
	logic rd_vld_d;

	// ----------------------------------------------------------
	// Bus drive and read capture
	// ----------------------------------------------------------
	assign sdram_dq = dq_oe ? wr_data_q : {dq_width{1'bz}};

	always_ff @(posedge clk)
	begin
		if (wr_drive)
			wr_data_q <= wr_burst_data; // Word follows its request by a cycle
		if (rd_pend)
			rd_burst_data <= sdram_dq;
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			dq_oe           <= 1'b0;
			rd_pend         <= 1'b0;
			wr_req_d        <= 1'b0;
			rd_vld_d        <= 1'b0;
			wr_burst_finish <= 1'b0;
			rd_burst_finish <= 1'b0;
		end
		else
		begin
			dq_oe           <= wr_drive;
			rd_pend         <= rd_capture;
			wr_req_d        <= wr_burst_data_req;
			rd_vld_d        <= rd_burst_data_valid;
			wr_burst_finish <= wr_req_d & ~wr_burst_data_req; // Falling edge, one cycle late
			rd_burst_finish <= rd_vld_d & ~rd_burst_data_valid;
		end
	end

	a_no_bus_fight: assert property (@(posedge clk) disable iff (rst) !(dq_oe && rd_capture));

endmodule

`default_nettype wire

/* sdram_ctrl/sdram_refresh_timer.sv */
`timescale 1ns/1ps
`default_nettype none

module sdram_refresh_timer #(
	parameter int power_up_cycles  = 20000, // 200 us at 100 MHz
	parameter int refresh_interval = 750    // 7.5 us at 100 MHz
) (
	input  wire  clk,
	input  wire  rst,
	input  wire  ref_ack,
	output logic init_go,
	output logic ref_req
);

	localparam int cnt_max = (power_up_cycles > refresh_interval) ?
		power_up_cycles : refresh_interval;
	localparam int cnt_w = $clog2(cnt_max + 1);

	logic [cnt_w-1:0] cnt;     // Power-up count first, then interval count
	logic             cnt_end; // Last cycle of the current period

	assign cnt_end = init_go ? (cnt == cnt_w'(refresh_interval - 1)) :
		(cnt == cnt_w'(power_up_cycles - 1));

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			cnt     <= '0;
			init_go <= 1'b0;
			ref_req <= 1'b0;
		end
		else
		begin
			cnt <= cnt_end ? '0 : cnt + 1'b1; // Free running after power-up
			if (cnt_end)
				init_go <= 1'b1;            // Sticky
			if (init_go && cnt_end)
				ref_req <= 1'b1;            // New expiry wins over ack
			else if (ref_ack)
				ref_req <= 1'b0;
		end
	end

	a_ack_has_req: assert property (@(posedge clk) disable iff (rst) ref_ack |-> ref_req);

endmodule

`default_nettype wire

/* sdram_ctrl/sdram_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module sdram_sequencer #(
	parameter int t_rp        = 4, // All waits need at least 2
	parameter int t_rc        = 6,
	parameter int t_mrd       = 6,
	parameter int t_rcd       = 2,
	parameter int t_wr        = 3,
	parameter int cas_latency = 3  // 2 or 3
) (
	input  wire                   clk,
	input  wire                   rst,
	input  wire                   init_go,
	input  wire                   ref_req,
	output logic                  ref_ack,
	input  wire                   wr_burst_req,
	input  wire                   rd_burst_req,
	input  wire sdram_pkg::burst_len_t wr_burst_len,
	input  wire sdram_pkg::burst_len_t rd_burst_len,
	input  wire sdram_pkg::app_addr_t  wr_burst_addr,
	input  wire sdram_pkg::app_addr_t  rd_burst_addr,
	output logic                  wr_burst_data_req,
	output logic                  rd_burst_data_valid,
	output sdram_pkg::seq_ctrl_t  seq_ctrl
);

	import sdram_pkg::*;

	localparam int rd_align = 3; // rd_capture to word in the data path register

	seq_state_t           state, state_nxt;
	logic [dly_width-1:0] dly;       // Cycles since the state was entered
	logic                 rd_sel;    // 1 = read burst in progress
	app_addr_t            addr_q;
	burst_len_t           len_q;
	app_addr_t            sel_addr;  // Request side mux, valid in idle
	app_addr_t            cur_addr;
	logic                 accept;
	logic                 burst_last, wr_more;
	logic                 wait_rp, wait_rc, wait_mrd, wait_rcd, wait_wr, wait_cl;
	logic [rd_align-1:0]  rd_vld_sr;

	// ----------------------------------------------------------
	// Delay ends, each on the last wait cycle
	// ----------------------------------------------------------
	assign wait_rp    = (dly == dly_width'(t_rp - 2));
	assign wait_rc    = (dly == dly_width'(t_rc - 2));
	assign wait_mrd   = (dly == dly_width'(t_mrd - 2));
	assign wait_rcd   = (dly == dly_width'(t_rcd - 2));
	assign wait_wr    = (dly == dly_width'(t_wr - 2));
	assign wait_cl    = (dly == dly_width'(cas_latency - 3));
	assign burst_last = (dly == (len_q - burst_len_t'(1)));
	assign wr_more    = ({1'b0, dly} + 2'd2) < {1'b0, len_q}; // Words still to request

	assign accept   = (state == st_idle) && !ref_req && (wr_burst_req || rd_burst_req);
	assign sel_addr = wr_burst_req ? wr_burst_addr : rd_burst_addr; // Write over read
	assign cur_addr = (state == st_idle) ? sel_addr : addr_q;

	always_comb
	begin
		state_nxt = state;
		case (state)
			st_pwr_wait:  if (init_go) state_nxt = st_init_pre;
			st_init_pre:  state_nxt = st_init_trp;
			st_init_trp:  if (wait_rp) state_nxt = st_init_ar1;
			st_init_ar1:  state_nxt = st_init_trf1;
			st_init_trf1: if (wait_rc) state_nxt = st_init_ar2;
			st_init_ar2:  state_nxt = st_init_trf2;
			st_init_trf2: if (wait_rc) state_nxt = st_init_mrs;
			st_init_mrs:  state_nxt = st_init_tmrd;
			st_init_tmrd: if (wait_mrd) state_nxt = st_idle;
			st_idle:      state_nxt = ref_req ? st_ref : (accept ? st_act_wait : st_idle);
			st_act_wait:  if (wait_rcd) state_nxt = rd_sel ? st_read : st_write;
			st_read:      state_nxt = (cas_latency > 2) ? st_cas_wait : st_rd_data;
			st_cas_wait:  if (wait_cl) state_nxt = st_rd_data;
			st_rd_data:   if (burst_last) state_nxt = st_pre; // BST then close the row
			st_write:     state_nxt = st_wr_data;
			st_wr_data:   if (burst_last) state_nxt = st_wr_rec;
			st_wr_rec:    if (wait_wr) state_nxt = st_pre;
			st_pre:       state_nxt = st_pre_wait;
			st_pre_wait:  if (wait_rp) state_nxt = st_idle;
			st_ref:       state_nxt = st_ref_wait;
			st_ref_wait:  if (wait_rc) state_nxt = st_idle;
			default:      state_nxt = st_pwr_wait;
		endcase
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			state     <= st_pwr_wait;
			dly       <= '0;
			rd_sel    <= 1'b0;
			rd_vld_sr <= '0;
		end
		else
		begin
			state     <= state_nxt;
			dly       <= (state_nxt != state) ? '0 : dly + 1'b1;
			rd_vld_sr <= {rd_vld_sr[rd_align-2:0], seq_ctrl.rd_capture};
			if (state == st_idle)
				rd_sel <= !wr_burst_req; // Last idle cycle is the accepted one
		end
	end

	always_ff @(posedge clk)
	begin
		if (state == st_idle)
		begin
			addr_q <= sel_addr;
			len_q  <= wr_burst_req ? wr_burst_len : rd_burst_len;
		end
	end

	// ----------------------------------------------------------
	// Strobes and the operation stream
	// ----------------------------------------------------------
	assign ref_ack             = (state == st_ref);
	assign rd_burst_data_valid = rd_vld_sr[rd_align-1];
	assign wr_burst_data_req   = !rd_sel && ((state == st_act_wait && wait_rcd) ||
		(state == st_write && len_q > burst_len_t'(1)) || (state == st_wr_data && wr_more));

	always_comb
	begin
		seq_ctrl.op         = op_nop;
		seq_ctrl.bank       = cur_addr[addr_width-1 -: ba_width];
		seq_ctrl.row        = cur_addr[col_width +: row_width];
		seq_ctrl.col        = cur_addr[col_width-1:0];
		seq_ctrl.wr_drive   = wr_burst_data_req; // Word arrives next cycle
		seq_ctrl.rd_capture = (state == st_rd_data);
		case (state)
			st_init_pre, st_pre:              seq_ctrl.op = op_precharge_all;
			st_init_ar1, st_init_ar2, st_ref: seq_ctrl.op = op_auto_refresh;
			st_init_mrs:                      seq_ctrl.op = op_load_mode;
			st_idle:                          seq_ctrl.op = accept ? op_activate : op_nop;
			st_read:                          seq_ctrl.op = op_read;
			st_write:                         seq_ctrl.op = op_write;
			st_rd_data, st_wr_data:           seq_ctrl.op = burst_last ? op_burst_stop : op_nop;
			default:                          seq_ctrl.op = op_nop;
		endcase
	end

	a_strobes_apart: assert property (@(posedge clk) disable iff (rst)
		!(wr_burst_data_req && rd_burst_data_valid));

endmodule

`default_nettype wire

/* verification/sdram_model.sv */
`timescale 1ns/1ps
`default_nettype none

module sdram_model #(
	parameter int cas_latency = 3
) (
	input  wire                   clk,
	input  wire                   ras_n,
	input  wire                   cas_n,
	input  wire                   we_n,
	input  wire sdram_pkg::bank_t ba,
	input  wire sdram_pkg::row_t  addr,
	inout  wire sdram_pkg::dq_t   dq
);

	import sdram_pkg::*;

	dq_t                  mem [int];       // Sparse storage, key {bank, row, col}
	row_t                 open_row [4];
	logic                 wr_on = 1'b0;    // Full-page write running
	logic                 rd_on = 1'b0;    // Full-page read running
	bank_t                cur_bank;
	col_t                 cur_col;
	logic [cas_latency-1:0] rd_vld = '0;   // CAS latency pipeline
	dq_t                  rd_pipe [cas_latency];

	assign dq = rd_vld[cas_latency-1] ? rd_pipe[cas_latency-1] : {dq_width{1'bz}};

	function automatic int peek(int k);
		return mem.exists(k) ? int'(mem[k]) : -1; // -1 for never written
	endfunction

	always @(posedge clk)
	begin
		logic [2:0] cmd;
		col_t       col;
		int         k;
		cmd = {ras_n, cas_n, we_n};
		col = cur_col;
		case (cmd)
			3'b011: open_row[ba] = addr;  // ACTIVE
			3'b100, 3'b101:               // WRITE or READ starts a page burst
			begin
				wr_on    = (cmd == 3'b100);
				rd_on    = (cmd == 3'b101);
				cur_bank = ba;
				col      = addr[col_width-1:0];
			end
			3'b110, 3'b010:               // BURST TERMINATE or PRECHARGE
			begin
				wr_on = 1'b0;
				rd_on = 1'b0;
			end
			default: ;
		endcase
		k = int'({cur_bank, open_row[cur_bank], col});
		if (wr_on)
			mem[k] = dq;                  // Bus value from the previous cycle
		rd_vld     <= {rd_vld[cas_latency-2:0], rd_on};
		rd_pipe[0] <= (rd_on && mem.exists(k)) ? mem[k] : 'x;
		for (int i = 1; i < cas_latency; i++)
			rd_pipe[i] <= rd_pipe[i-1];
		cur_col = col + 1'b1;             // Wraps inside the page
	end

endmodule

`default_nettype wire

/* verification/tb_sdram_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_sdram_ctrl;

	import sdram_pkg::*;

	localparam int max_len    = 200;  // Random burst limit
	localparam int idle_cyc   = 1200;
	localparam int run_cycles = 16 + 100 + 200 + 2 * (max_len + 100) + idle_cyc +
		4 * (64 + 100) + 2000;        // Test lengths plus margin

	logic       clk, rst;
	logic       wr_burst_req, rd_burst_req;
	burst_len_t wr_burst_len, rd_burst_len;
	app_addr_t  wr_burst_addr, rd_burst_addr;
	dq_t        wr_burst_data, rd_burst_data;
	logic       wr_burst_data_req, wr_burst_finish, rd_burst_data_valid, rd_burst_finish;
	logic       sdram_cke, sdram_cs_n, sdram_ras_n, sdram_cas_n, sdram_we_n;
	bank_t      sdram_ba;
	row_t       sdram_addr;
	logic [1:0] sdram_dqm;
	wire dq_t   sdram_dq;

	int         errors = 0;
	int         cycle = 0;             // Cycles since reset release
	int         cmd_count = 0, ref_count = 0, ref_in_row = 0, first_cmd_cycle = -1;
	logic [2:0] first_cmd [4];
	row_t       first_addr [4];
	bank_t      first_ba [4];
	logic       row_open = 1'b0;
	dq_t        exp_mem [int];         // Expected contents

	sdram_ctrl #(.power_up_cycles(100), .refresh_interval(400)) uut (.*);

	sdram_model u_mem (.clk, .ras_n(sdram_ras_n), .cas_n(sdram_cas_n), .we_n(sdram_we_n),
		.ba(sdram_ba), .addr(sdram_addr), .dq(sdram_dq));

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	initial
	begin
		repeat (run_cycles) @(posedge clk);
		$display("Watchdog expired after %0d cycles", run_cycles);
		$display("Regression failed");
		$finish;
	end

	// ----------------------------------------------------------
	// Command monitor
	// ----------------------------------------------------------
	always @(posedge clk)
	begin
		logic [2:0] cmd;
		cmd = {sdram_ras_n, sdram_cas_n, sdram_we_n};
		if (!rst)
		begin
			cycle <= cycle + 1;
			if (cmd != 3'b111)
			begin
				if (cmd_count < 4)
				begin
					first_cmd[cmd_count]  = cmd;
					first_addr[cmd_count] = sdram_addr;
					first_ba[cmd_count]   = sdram_ba;
				end
				if (first_cmd_cycle < 0)
					first_cmd_cycle = cycle;
				cmd_count++;
			end
			if (cmd == 3'b011)
				row_open = 1'b1;
			if (cmd == 3'b010)
				row_open = 1'b0;
			if (cmd == 3'b001)
			begin
				ref_count++;
				if (row_open)
					ref_in_row++; // Refresh with a row still open
			end
		end
	end

	task automatic report_mismatch(input string name, input logic [31:0] exp, act);
		errors++;
		$display("FAILED %s: expected %h, actual %h", name, exp, act);
	endtask

	function automatic int addr_key(input app_addr_t a, input int i);
		col_t c;
		c = a[col_width-1:0] + col_t'(i); // Column wraps inside the page
		return int'({a[addr_width-1 -: ba_width], a[col_width +: row_width], c});
	endfunction

	task automatic check_idle_pins(input string name);
		if ({sdram_ras_n, sdram_cas_n, sdram_we_n} !== 3'b111)
			report_mismatch(name, 3'b111, {sdram_ras_n, sdram_cas_n, sdram_we_n});
		if (sdram_ba !== '1 || sdram_addr !== '1)
			report_mismatch(name, 32'h7fff, {sdram_ba, sdram_addr});
		if (sdram_cke !== 1'b1 || sdram_cs_n !== 1'b0)
			report_mismatch(name, 2'b10, {sdram_cke, sdram_cs_n});
		if (sdram_dqm !== 2'b00)
			report_mismatch(name, 2'b00, sdram_dqm);
		if ({wr_burst_data_req, rd_burst_data_valid, wr_burst_finish, rd_burst_finish} !== 0)
			report_mismatch(name, 0, {wr_burst_data_req, rd_burst_data_valid,
				wr_burst_finish, rd_burst_finish});
	endtask

	task automatic check_init();
		int n;
		n = 0;
		while (cmd_count < 4 && n < 400)
		begin
			@(posedge clk);
			#1;
			n++;
		end
		if (cmd_count < 4)
		begin
			errors++;
			$display("Init sequence did not issue four commands");
		end
		if (first_cmd_cycle < 100)
			report_mismatch("init first cycle", 100, first_cmd_cycle);
		if (first_cmd[0] !== 3'b010 || first_addr[0][10] !== 1'b1)
			report_mismatch("init precharge", 3'b010, first_cmd[0]);
		if (first_cmd[1] !== 3'b001 || first_cmd[2] !== 3'b001)
			report_mismatch("init refresh", 6'o11, {first_cmd[1], first_cmd[2]});
		if (first_cmd[3] !== 3'b000)
			report_mismatch("init load mode", 3'b000, first_cmd[3]);
		// Full page, sequential, CAS latency in A6..A4, burst write
		if (first_addr[3] !== row_t'(13'h007 | (3 << 4)) || first_ba[3] !== 2'b00)
			report_mismatch("mode word", 13'h037, first_addr[3]);
	endtask

	// ----------------------------------------------------------
	// Burst tests
	// ----------------------------------------------------------
	task automatic write_burst(input string name, input app_addr_t a, input int len);
		int   n_req, n_fin, idx, n;
		logic prev, fell;
		n_req = 0;
		n_fin = 0;
		idx   = 0;
		n     = 0;
		prev  = 1'b0;
		fell  = 1'b0;
		wr_burst_addr = a;
		wr_burst_len  = burst_len_t'(len);
		wr_burst_req  = 1'b1;
		while (n_fin == 0 && n < len + 3000)
		begin
			@(posedge clk);
			#1;
			n++;
			if (prev)
			begin
				wr_burst_data = dq_t'($urandom); // Word follows its request
				exp_mem[addr_key(a, idx)] = wr_burst_data;
				idx++;
			end
			if (wr_burst_data_req && fell)
			begin
				errors++;
				$display("%s: write request strobe has a gap", name);
			end
			fell  = fell || (prev && !wr_burst_data_req);
			n_req += wr_burst_data_req;
			n_fin += wr_burst_finish;
			prev  = wr_burst_data_req;
		end
		wr_burst_req = 1'b0;
		repeat (4)
		begin
			@(posedge clk);
			#1;
			n_fin += wr_burst_finish;
		end
		if (n_req != len)
			report_mismatch({name, " request count"}, len, n_req);
		if (n_fin != 1)
			report_mismatch({name, " finish pulses"}, 1, n_fin);
		for (int i = 0; i < len; i++)
			if (u_mem.peek(addr_key(a, i)) != int'(exp_mem[addr_key(a, i)]))
				report_mismatch({name, " stored word"}, exp_mem[addr_key(a, i)],
					u_mem.peek(addr_key(a, i)));
	endtask

	task automatic read_burst(input string name, input app_addr_t a, input int len);
		int n_vld, n_fin, n;
		n_vld = 0;
		n_fin = 0;
		n     = 0;
		rd_burst_addr = a;
		rd_burst_len  = burst_len_t'(len);
		rd_burst_req  = 1'b1;
		while (n_fin == 0 && n < len + 3000)
		begin
			@(posedge clk);
			#1;
			n++;
			if (rd_burst_data_valid)
			begin
				if (rd_burst_data !== exp_mem[addr_key(a, n_vld)])
					report_mismatch({name, " read word"}, exp_mem[addr_key(a, n_vld)],
						rd_burst_data);
				n_vld++;
			end
			n_fin += rd_burst_finish;
		end
		rd_burst_req = 1'b0;
		repeat (4)
		begin
			@(posedge clk);
			#1;
			n_fin += rd_burst_finish;
			n_vld += rd_burst_data_valid;
		end
		if (n_vld != len)
			report_mismatch({name, " valid count"}, len, n_vld);
		if (n_fin != 1)
			report_mismatch({name, " finish pulses"}, 1, n_fin);
	endtask

	task automatic idle_refresh();
		int start;
		start = ref_count;
		repeat (idle_cyc) @(posedge clk);
		#1;
		if (ref_count - start < 2)
			report_mismatch("idle refresh count", 2, ref_count - start);
		if (ref_in_row != 0)
			report_mismatch("refresh inside open row", 0, ref_in_row);
	endtask

	initial
	begin
		app_addr_t a1, a2;
		int        len;
		void'($urandom(32'h2d38));
		rst = 1'b1;
		{wr_burst_req, rd_burst_req} = 2'b00;
		wr_burst_len  = '0;
		rd_burst_len  = '0;
		wr_burst_addr = '0;
		rd_burst_addr = '0;
		wr_burst_data = '0;
		repeat (8) @(posedge clk);
		#1;
		check_idle_pins("during reset");
		repeat (8) @(posedge clk);
		#1;
		rst = 1'b0;
		@(posedge clk);
		#1;
		check_idle_pins("after reset");
		check_init();
		a1  = app_addr_t'($urandom);
		len = 1 + ($urandom % max_len);
		write_burst("random write", a1, len);
		read_burst("random read", a1, len);
		idle_refresh();
		a1 = app_addr_t'($urandom);
		a2 = app_addr_t'($urandom);
		a2[addr_width-1 -: ba_width] = a1[addr_width-1 -: ba_width] ^ 2'b01;
		a2[col_width +: row_width]   = ~a1[col_width +: row_width];
		write_burst("b2b write 1", a1, 1);
		write_burst("b2b write 64", a2, 64);
		read_burst("b2b read 1", a1, 1);
		read_burst("b2b read 64", a2, 64);
		$display("Closing report: %0d errors, %0d commands, %0d refreshes",
			errors, cmd_count, ref_count);
		if (errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

`default_nettype wire

/* vlog.f */
common/sdram_pkg.sv
sdram_ctrl/sdram_refresh_timer.sv
sdram_ctrl/sdram_sequencer.sv
sdram_ctrl/sdram_cmd_encoder.sv
sdram_ctrl/sdram_data_path.sv
sdram_ctrl/sdram_ctrl.sv
verification/sdram_model.sv
verification/tb_sdram_ctrl.sv
